// File: design/nn_cfg.svh
// Network shape, word widths, register map and parameter memory layout
// Parameter offsets are derived by hand from the layer sizes below
// Any change to a layer size needs the offsets and NN_PARAM_WORDS redone
`ifndef NN_CFG_SVH
`define NN_CFG_SVH

// Layer sizes
`define NN_INPUTS       32
`define NN_HIDDEN1      8
`define NN_HIDDEN2      8
`define NN_OUTPUTS      4

// Q8.8 words
`define NN_WORD_BITS    16
`define NN_FRAC_BITS    8

`define AXI_ADDR_BITS   32
`define AXI_DATA_BITS   32

// Word addresses (byte address >> 2)
`define NN_FEAT_ADDR    0
`define NN_RESULT_ADDR  1
`define NN_PARAM_BASE   512

// Parameter memory layout, weights neuron-major
`define NN_W1_OFS       0
`define NN_W2_OFS       256
`define NN_W3_OFS       320
`define NN_B1_OFS       352
`define NN_B2_OFS       360
`define NN_B3_OFS       368
`define NN_PARAM_WORDS  372

`endif

// File: design/nn_pkg.sv
// Types shared by the bus front end and the inference engine
// Activations and parameters are both signed Q8.8 words
package nn_pkg;

    `include "nn_cfg.svh"

    // ==========================================================================
    // Data and address types
    // ==========================================================================
    typedef logic signed [`NN_WORD_BITS-1:0] act_t;

    typedef logic [$clog2(`NN_PARAM_WORDS)-1:0] param_addr_t;   // 9 bits

    typedef logic [$clog2(`NN_OUTPUTS)-1:0] class_t;

    // ==========================================================================
    // State encodings
    // ==========================================================================
    typedef enum logic [2:0] {
        IDLE,
        WRITE,
        WRESP,
        RADDR,
        INFER,   // Waiting on the engine for a result read
        RDATA
    } axil_state_t;

    typedef enum logic [1:0] {
        L1,
        L2,
        L3
    } layer_t;

endpackage

// File: design/nn_bus_if.sv
`timescale 1ns/1ps
// Internal bus between the AXI front end, the parameter memory and the engine
// The host read address is only honoured while busy is low
`include "nn_cfg.svh"

interface nn_bus_if;
    import nn_pkg::*;

    // Host side
    logic                  wr_en;
    param_addr_t           wr_addr;
    act_t                  wr_data;
    param_addr_t           rd_addr_bus;
    logic [`NN_INPUTS-1:0] features;
    logic                  start;         // One-cycle pulse

    act_t                  rd_data;       // One cycle after the address

    // Engine side
    param_addr_t           rd_addr_eng;
    logic                  busy;
    logic                  done;          // One-cycle pulse
    class_t                prediction;

    modport ctrl (output wr_en, wr_addr, wr_data, rd_addr_bus, features, start,
                  input  rd_data, done, prediction);

    modport mem  (input  wr_en, wr_addr, wr_data, rd_addr_bus, rd_addr_eng, busy,
                  output rd_data);

    modport eng  (input  features, start, rd_data,
                  output rd_addr_eng, busy, done, prediction);

endinterface

// File: design/axil_slave_fsm.sv
`timescale 1ns/1ps
// AXI4-Lite slave front end, one transaction at a time
// Write wins when AWVALID and ARVALID arrive together
// Responses are always OKAY and every write stores the full word
// Unmapped words read as zero; writes to them and to the result word are dropped
// A result read stalls in INFER until the engine reports done
`include "nn_cfg.svh"

module axil_slave_fsm (
    input  logic                      ACLK,
    input  logic                      rst,
    input  logic [`AXI_ADDR_BITS-1:0] i_araddr,
    input  logic                      i_arvalid,
    input  logic                      i_rready,
    input  logic [`AXI_ADDR_BITS-1:0] i_awaddr,
    input  logic                      i_awvalid,
    input  logic [`AXI_DATA_BITS-1:0] i_wdata,
    input  logic                      i_wvalid,
    input  logic                      i_bready,
    output logic                      o_arready,
    output logic [`AXI_DATA_BITS-1:0] o_rdata,
    output logic [1:0]                o_rresp,
    output logic                      o_rvalid,
    output logic                      o_awready,
    output logic                      o_wready,
    output logic [1:0]                o_bresp,
    output logic                      o_bvalid,
    nn_bus_if.ctrl                    bus
);
    import nn_pkg::*;

    localparam int WORD_BITS = `AXI_ADDR_BITS - 2;
    localparam int DATA_BITS = `AXI_DATA_BITS;
    localparam int EXT_BITS  = `AXI_DATA_BITS - `NN_WORD_BITS;

    typedef logic [WORD_BITS-1:0] word_t;

    axil_state_t          state;
    axil_state_t          next_state;
    word_t                ar_word;
    word_t                aw_word;
    word_t                rd_word;     // Latched read address
    logic                 aw_hs;
    logic [DATA_BITS-1:0] rdata_mux;

    function automatic logic in_params(word_t w);
        return (w >= word_t'(`NN_PARAM_BASE)) &&
               (w < word_t'(`NN_PARAM_BASE + `NN_PARAM_WORDS));
    endfunction

    function automatic param_addr_t param_idx(word_t w);
        return param_addr_t'(w - word_t'(`NN_PARAM_BASE));
    endfunction

    assign ar_word = i_araddr[`AXI_ADDR_BITS-1:2];
    assign aw_word = i_awaddr[`AXI_ADDR_BITS-1:2];
    assign aw_hs   = (state == WRITE) && i_awvalid && i_wvalid;

    // ==========================================================================
    // Channel outputs, all decoded from the state
    // ==========================================================================
    assign o_awready = (state == WRITE);
    assign o_wready  = (state == WRITE);
    assign o_bvalid  = (state == WRESP);
    assign o_bresp   = 2'b00;
    assign o_arready = (state == RADDR);
    assign o_rvalid  = (state == RDATA);
    assign o_rresp   = 2'b00;
    assign o_rdata   = (state == RDATA) ? rdata_mux : '0;

    assign bus.wr_en   = aw_hs && in_params(aw_word);
    assign bus.wr_addr = param_idx(aw_word);
    assign bus.wr_data = act_t'(i_wdata[`NN_WORD_BITS-1:0]);

    // Issue the read in RADDR, then keep re-reading the latched word in RDATA
    assign bus.rd_addr_bus = (state == RADDR) ? param_idx(ar_word) : param_idx(rd_word);

    assign bus.start = (state == RADDR) && i_arvalid &&
                       (ar_word == word_t'(`NN_RESULT_ADDR));

    always_comb begin
        rdata_mux = '0;
        if (rd_word == word_t'(`NN_FEAT_ADDR)) begin
            rdata_mux = DATA_BITS'(bus.features);
        end else if (rd_word == word_t'(`NN_RESULT_ADDR)) begin
            rdata_mux = DATA_BITS'(bus.prediction);   // Class in bits 1:0
        end else if (in_params(rd_word)) begin
            rdata_mux = {{EXT_BITS{bus.rd_data[`NN_WORD_BITS-1]}}, bus.rd_data};
        end
    end

    // ==========================================================================
    // State machine
    // ==========================================================================
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (i_awvalid)
                    next_state = WRITE;
                else if (i_arvalid)
                    next_state = RADDR;
            end
            WRITE: begin
                if (aw_hs)
                    next_state = WRESP;
            end
            WRESP: begin
                if (i_bready)
                    next_state = IDLE;
            end
            RADDR: begin
                if (bus.start)
                    next_state = INFER;
                else if (i_arvalid)
                    next_state = RDATA;
            end
            INFER: begin
                if (bus.done)
                    next_state = RDATA;
            end
            RDATA: begin
                if (i_rready)
                    next_state = IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge ACLK or posedge rst) begin
        if (rst) begin
            state        <= IDLE;
            rd_word      <= '0;
            bus.features <= '0;
        end else begin
            state <= next_state;
            if (state == RADDR && i_arvalid)
                rd_word <= ar_word;
            if (aw_hs && aw_word == word_t'(`NN_FEAT_ADDR))
                bus.features <= i_wdata[`NN_INPUTS-1:0];   // One bit per input
        end
    end

endmodule

// File: design/param_mem.sv
`timescale 1ns/1ps
// Parameter store for all weights and biases, signed Q8.8
// Contents are undefined until the host has loaded every word
// The engine owns the read port while busy is high
`include "nn_cfg.svh"

module param_mem (
    input logic   ACLK,
    nn_bus_if.mem bus
);
    import nn_pkg::*;

    act_t        mem [`NN_PARAM_WORDS];
    param_addr_t rd_addr;

    assign rd_addr = bus.busy ? bus.rd_addr_eng : bus.rd_addr_bus;

    always_ff @(posedge ACLK) begin
        if (bus.wr_en)
            mem[bus.wr_addr] <= bus.wr_data;
        bus.rd_data <= mem[rd_addr];   // Registered read
    end

endmodule

// File: design/infer_seq.sv
`timescale 1ns/1ps
// Inference sequencer for the three layers, run strictly in order
// Each neuron reads its bias first, then one weight per cycle
// Datapath strobes trail the memory address by one cycle
// A start pulse while busy is not expected
`include "nn_cfg.svh"

module infer_seq (
    input  logic           ACLK,
    input  logic           rst,
    nn_bus_if.eng          bus,
    output nn_pkg::layer_t o_layer,
    output logic [2:0]     o_neuron,
    output logic [4:0]     o_input,
    output logic           o_acc_load,
    output logic           o_acc_step,
    output logic           o_neuron_end
);
    import nn_pkg::*;

    logic       run;        // Issue stage active
    logic       bias_ph;    // Current slot reads the bias
    layer_t     layer;
    logic [2:0] neuron;
    logic [4:0] inp;
    logic [4:0] last_in;
    logic [2:0] last_n;
    logic       row_end;

    // Fan-in and neuron count of the current layer
    always_comb begin
        case (layer)
            L1: begin
                last_in = 5'(`NN_INPUTS - 1);
                last_n  = 3'(`NN_HIDDEN1 - 1);
            end
            L2: begin
                last_in = 5'(`NN_HIDDEN1 - 1);
                last_n  = 3'(`NN_HIDDEN2 - 1);
            end
            default: begin
                last_in = 5'(`NN_HIDDEN2 - 1);
                last_n  = 3'(`NN_OUTPUTS - 1);
            end
        endcase
    end

    assign row_end = !bias_ph && (inp == last_in);

    // ==========================================================================
    // Memory address for the current slot
    // ==========================================================================
    always_comb begin
        case (layer)
            L1: bus.rd_addr_eng = bias_ph ?
                    param_addr_t'(`NN_B1_OFS + neuron) :
                    param_addr_t'(`NN_W1_OFS + neuron * `NN_INPUTS + inp);
            L2: bus.rd_addr_eng = bias_ph ?
                    param_addr_t'(`NN_B2_OFS + neuron) :
                    param_addr_t'(`NN_W2_OFS + neuron * `NN_HIDDEN1 + inp);
            default: bus.rd_addr_eng = bias_ph ?
                    param_addr_t'(`NN_B3_OFS + neuron) :
                    param_addr_t'(`NN_W3_OFS + neuron * `NN_HIDDEN2 + inp);
        endcase
    end

    always_ff @(posedge ACLK or posedge rst) begin
        if (rst) begin
            run          <= 1'b0;
            bias_ph      <= 1'b1;
            layer        <= L1;
            neuron       <= '0;
            inp          <= '0;
            o_layer      <= L1;
            o_neuron     <= '0;
            o_input      <= '0;
            o_acc_load   <= 1'b0;
            o_acc_step   <= 1'b0;
            o_neuron_end <= 1'b0;
            bus.busy     <= 1'b0;
            bus.done     <= 1'b0;
        end else begin
            // Datapath stage, aligned with rd_data
            o_acc_load   <= run && bias_ph;
            o_acc_step   <= run && !bias_ph;
            o_neuron_end <= run && row_end;
            o_layer      <= layer;
            o_neuron     <= neuron;
            o_input      <= inp;

            // Last output neuron has just been written
            bus.done <= o_neuron_end && (o_layer == L3) &&
                        (o_neuron == 3'(`NN_OUTPUTS - 1));

            if (bus.start) begin
                run      <= 1'b1;
                bus.busy <= 1'b1;
                bias_ph  <= 1'b1;
                layer    <= L1;
                neuron   <= '0;
                inp      <= '0;
            end else if (run) begin
                if (bias_ph) begin
                    bias_ph <= 1'b0;
                end else if (row_end) begin
                    bias_ph <= 1'b1;
                    inp     <= '0;
                    if (neuron == last_n) begin
                        neuron <= '0;
                        if (layer == L3)
                            run <= 1'b0;   // Pipeline drains on its own
                        else
                            layer <= (layer == L1) ? L2 : L3;
                    end else begin
                        neuron <= neuron + 3'd1;
                    end
                end else begin
                    inp <= inp + 5'd1;
                end
            end

            if (bus.done)
                bus.busy <= 1'b0;
        end
    end

endmodule

// File: design/mac_datapath.sv
`timescale 1ns/1ps
// Accumulate datapath for all three layers
// Sums wrap at 16 bits; Q8.8 products are scaled back by an arithmetic shift
// ReLU on the hidden layers only; argmax ties go to the lowest class
// Prediction changes only on done
`include "nn_cfg.svh"

module mac_datapath (
    input  logic           ACLK,
    input  logic           rst,
    input  nn_pkg::layer_t i_layer,
    input  logic [2:0]     i_neuron,
    input  logic [4:0]     i_input,
    input  logic           i_acc_load,
    input  logic           i_acc_step,
    input  logic           i_neuron_end,
    nn_bus_if.eng          bus
);
    import nn_pkg::*;

    localparam int PROD_BITS = 2 * `NN_WORD_BITS;

    act_t                  hid1 [`NN_HIDDEN1];
    act_t                  hid2 [`NN_HIDDEN2];
    act_t                  acc;
    act_t                  prev_act;   // Activation paired with this weight
    act_t                  contrib;
    act_t                  acc_next;
    act_t                  best_val;
    class_t                best_idx;
    logic signed [PROD_BITS-1:0] prod;
    logic signed [PROD_BITS-1:0] prod_scaled;

    function automatic act_t relu(act_t x);
        return x[`NN_WORD_BITS-1] ? '0 : x;
    endfunction

    // ==========================================================================
    // Contribution of one weight
    // ==========================================================================
    assign prev_act    = (i_layer == L2) ? hid1[i_input[2:0]] : hid2[i_input[2:0]];
    assign prod        = prev_act * bus.rd_data;
    assign prod_scaled = prod >>> `NN_FRAC_BITS;

    // Layer 1 inputs are single bits, so the weight is simply gated
    assign contrib  = (i_layer == L1) ?
                      (bus.features[i_input] ? bus.rd_data : '0) :
                      act_t'(prod_scaled[`NN_WORD_BITS-1:0]);
    assign acc_next = acc + contrib;

    always_ff @(posedge ACLK) begin
        if (i_acc_load)
            acc <= bus.rd_data;    // Bias seeds the sum
        else if (i_acc_step)
            acc <= acc_next;

        // Neuron end comes with its last weight, so store acc_next
        if (i_neuron_end) begin
            if (i_layer == L1)
                hid1[i_neuron] <= relu(acc_next);
            else if (i_layer == L2)
                hid2[i_neuron] <= relu(acc_next);
        end
    end

    // ==========================================================================
    // Running argmax over the output layer
    // ==========================================================================
    always_ff @(posedge ACLK or posedge rst) begin
        if (rst) begin
            best_val       <= '0;
            best_idx       <= '0;
            bus.prediction <= '0;
        end else begin
            if (i_neuron_end && i_layer == L3 &&
                (i_neuron == 3'd0 || acc_next > best_val)) begin
                best_val <= acc_next;
                best_idx <= class_t'(i_neuron);
            end
            if (bus.done)
                bus.prediction <= best_idx;
        end
    end

endmodule

// File: design/nn_axil_top.sv
`timescale 1ns/1ps
// AXI4-Lite neural network accelerator, top level
// Word 0 holds the 32 binary features and word 1 is the result
// Reading the result word runs one inference before the data returns
// Words from 512 up map onto the 372 parameter words
// WSTRB is not brought in, every write is a full word
`include "nn_cfg.svh"

module nn_axil_top (
    input  logic                      ACLK,
    input  logic                      rst,
    input  logic [`AXI_ADDR_BITS-1:0] i_araddr,
    input  logic                      i_arvalid,
    input  logic                      i_rready,
    input  logic [`AXI_ADDR_BITS-1:0] i_awaddr,
    input  logic                      i_awvalid,
    input  logic [`AXI_DATA_BITS-1:0] i_wdata,
    input  logic                      i_wvalid,
    input  logic                      i_bready,
    output logic                      o_arready,
    output logic [`AXI_DATA_BITS-1:0] o_rdata,
    output logic [1:0]                o_rresp,
    output logic                      o_rvalid,
    output logic                      o_awready,
    output logic                      o_wready,
    output logic [1:0]                o_bresp,
    output logic                      o_bvalid
);
    import nn_pkg::*;

    // Sequencer to datapath strobes
    layer_t     layer;
    logic [2:0] neuron;
    logic [4:0] inp;
    logic       acc_load;
    logic       acc_step;
    logic       neuron_end;

    nn_bus_if bus ();

    axil_slave_fsm u_fsm (
        .ACLK      (ACLK),
        .rst       (rst),
        .i_araddr  (i_araddr),
        .i_arvalid (i_arvalid),
        .i_rready  (i_rready),
        .i_awaddr  (i_awaddr),
        .i_awvalid (i_awvalid),
        .i_wdata   (i_wdata),
        .i_wvalid  (i_wvalid),
        .i_bready  (i_bready),
        .o_arready (o_arready),
        .o_rdata   (o_rdata),
        .o_rresp   (o_rresp),
        .o_rvalid  (o_rvalid),
        .o_awready (o_awready),
        .o_wready  (o_wready),
        .o_bresp   (o_bresp),
        .o_bvalid  (o_bvalid),
        .bus       (bus.ctrl)
    );

    param_mem u_mem (
        .ACLK (ACLK),
        .bus  (bus.mem)
    );

    infer_seq u_seq (
        .ACLK         (ACLK),
        .rst          (rst),
        .bus          (bus.eng),
        .o_layer      (layer),
        .o_neuron     (neuron),
        .o_input      (inp),
        .o_acc_load   (acc_load),
        .o_acc_step   (acc_step),
        .o_neuron_end (neuron_end)
    );

    mac_datapath u_mac (
        .ACLK         (ACLK),
        .rst          (rst),
        .i_layer      (layer),
        .i_neuron     (neuron),
        .i_input      (inp),
        .i_acc_load   (acc_load),
        .i_acc_step   (acc_step),
        .i_neuron_end (neuron_end),
        .bus          (bus.eng)
    );

endmodule

// File: sim/tb_nn_axil.sv
`timescale 1ns/1ps
// Self-checking testbench for the AXI4-Lite network accelerator
// Parameters are loaded over the bus and a behavioral model predicts each class
// Inputs change on rising edges and outputs are sampled on falling edges
// The first failed check ends the run
`include "nn_cfg.svh"

module tb_nn_axil;

    localparam int CLK_PERIOD      = 100;
    localparam int MAX_INFER       = 600;
    // Five worst-case inferences plus a generous allowance for the parameter loads
    localparam int WATCHDOG_CYCLES = 5 * MAX_INFER + 3 * `NN_PARAM_WORDS * 8;
    localparam logic [31:0] FEAT_BYTE   = 32'(`NN_FEAT_ADDR * 4);
    localparam logic [31:0] RESULT_BYTE = 32'(`NN_RESULT_ADDR * 4);

    logic                      ACLK;
    logic                      rst;
    logic [`AXI_ADDR_BITS-1:0] i_araddr;
    logic                      i_arvalid;
    logic                      i_rready;
    logic [`AXI_ADDR_BITS-1:0] i_awaddr;
    logic                      i_awvalid;
    logic [`AXI_DATA_BITS-1:0] i_wdata;
    logic                      i_wvalid;
    logic                      i_bready;
    logic                      o_arready;
    logic [`AXI_DATA_BITS-1:0] o_rdata;
    logic [1:0]                o_rresp;
    logic                      o_rvalid;
    logic                      o_awready;
    logic                      o_wready;
    logic [1:0]                o_bresp;
    logic                      o_bvalid;

    logic signed [15:0] params [`NN_PARAM_WORDS];   // Host copy of the parameter memory
    logic [15:0]        lfsr_state;

    nn_axil_top dut_i (.*);

    initial begin
        ACLK = 1'b0;
        forever #(CLK_PERIOD / 2) ACLK = ~ACLK;
    end

    // ========================================================================
    // Failure reporting and checks
    // ========================================================================
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else stop_with_failure($sformatf("MISMATCH at %0d ns: %s = 0x%08h, expected 0x%08h",
                                         $time, name, got, exp));
    endtask

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge ACLK);
        stop_with_failure($sformatf("Timeout at %0d ns: no bus response within %0d cycles",
                                    $time, WATCHDOG_CYCLES));
    end

    // ========================================================================
    // Stimulus helpers
    // ========================================================================
    // 16-bit Fibonacci LFSR with taps 16 14 13 11 and one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic signed [15:0] rand_param();
        logic [31:0] r;
        r = rand_bits(12);
        return {{4{r[11]}}, r[11:0]};   // Roughly +-8.0 in Q8.8
    endfunction

    function automatic logic [31:0] sext(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic logic [31:0] param_addr(input int idx);
        return 32'((`NN_PARAM_BASE + idx) * 4);
    endfunction

    // Completes the AW, W and B handshakes once AW and W are valid
    task automatic write_finish(input int bdelay);
        @(negedge ACLK);
        while (!o_awready)
            @(negedge ACLK);
        check_val("o_wready", 32'(o_wready), 32'd1);
        check_val("o_arready", 32'(o_arready), 32'd0);   // No read accepted during a write
        @(posedge ACLK);                                 // AW and W taken on this edge
        i_awvalid <= 1'b0;
        i_wvalid  <= 1'b0;
        repeat (bdelay) begin
            @(negedge ACLK);
            check_val("o_bvalid", 32'(o_bvalid), 32'd1);
            @(posedge ACLK);
        end
        i_bready <= 1'b1;
        @(negedge ACLK);
        check_val("o_bvalid", 32'(o_bvalid), 32'd1);
        check_val("o_bresp", 32'(o_bresp), 32'd0);
        @(posedge ACLK);
        i_bready <= 1'b0;
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data, input int bdelay);
        @(posedge ACLK);
        i_awaddr  <= addr;
        i_wdata   <= data;
        i_awvalid <= 1'b1;
        i_wvalid  <= 1'b1;
        write_finish(bdelay);
    endtask

    // Completes a read once AR is valid and holds RREADY low for rdelay cycles
    task automatic read_finish(input int rdelay, output logic [31:0] data);
        logic [31:0] held;
        @(negedge ACLK);
        while (!o_arready)
            @(negedge ACLK);
        @(posedge ACLK);
        i_arvalid <= 1'b0;
        @(negedge ACLK);
        while (!o_rvalid)
            @(negedge ACLK);      // Result reads wait out the inference here
        held = o_rdata;
        check_val("o_rresp", 32'(o_rresp), 32'd0);
        repeat (rdelay) begin
            @(posedge ACLK);
            @(negedge ACLK);
            check_val("o_rvalid", 32'(o_rvalid), 32'd1);
            check_val("o_rdata", o_rdata, held);
        end
        @(posedge ACLK);
        i_rready <= 1'b1;
        @(negedge ACLK);
        check_val("o_rvalid", 32'(o_rvalid), 32'd1);
        check_val("o_rdata", o_rdata, held);
        @(posedge ACLK);
        i_rready <= 1'b0;
        data = held;
    endtask

    task automatic axi_read(input logic [31:0] addr, input int rdelay, output logic [31:0] data);
        @(posedge ACLK);
        i_araddr  <= addr;
        i_arvalid <= 1'b1;
        read_finish(rdelay, data);
    endtask

    task automatic load_params();
        for (int i = 0; i < `NN_PARAM_WORDS; i++)
            axi_write(param_addr(i), sext(params[i]), 0);
    endtask

    task automatic param_roundtrip(input int bdelay, input int rdelay);
        int          idx;
        logic [31:0] wd;
        logic [31:0] rd;
        idx = int'(rand_bits(9)) % `NN_PARAM_WORDS;
        wd  = rand_bits(32);      // Upper half is noise that the DUT drops
        axi_write(param_addr(idx), wd, bdelay);
        params[idx] = wd[15:0];
        axi_read(param_addr(idx), rdelay, rd);
        check_val($sformatf("o_rdata[param %0d]", idx), rd, sext(wd[15:0]));
    endtask

    // ========================================================================
    // Reference model
    // ========================================================================
    function automatic logic signed [15:0] scaled_mul(input logic signed [15:0] a,
                                                      input logic signed [15:0] w);
        logic signed [31:0] p;
        p = 32'(a) * 32'(w);
        p = p >>> `NN_FRAC_BITS;
        return p[15:0];
    endfunction

    function automatic int ref_predict(input logic [31:0] feat);
        logic signed [15:0] h1 [`NN_HIDDEN1];
        logic signed [15:0] h2 [`NN_HIDDEN2];
        logic signed [15:0] acc;
        logic signed [15:0] best;
        int                 win;
        for (int n = 0; n < `NN_HIDDEN1; n++) begin
            acc = params[`NN_B1_OFS + n];
            for (int i = 0; i < `NN_INPUTS; i++)
                if (feat[i])
                    acc = acc + params[`NN_W1_OFS + n * `NN_INPUTS + i];
            h1[n] = (acc < 0) ? 16'sd0 : acc;
        end
        for (int n = 0; n < `NN_HIDDEN2; n++) begin
            acc = params[`NN_B2_OFS + n];
            for (int j = 0; j < `NN_HIDDEN1; j++)
                acc = acc + scaled_mul(h1[j], params[`NN_W2_OFS + n * `NN_HIDDEN1 + j]);
            h2[n] = (acc < 0) ? 16'sd0 : acc;
        end
        win  = 0;
        best = '0;
        for (int n = 0; n < `NN_OUTPUTS; n++) begin
            acc = params[`NN_B3_OFS + n];
            for (int j = 0; j < `NN_HIDDEN2; j++)
                acc = acc + scaled_mul(h2[j], params[`NN_W3_OFS + n * `NN_HIDDEN2 + j]);
            if (n == 0 || acc > best) begin   // Strict compare keeps the lowest index
                best = acc;
                win  = n;
            end
        end
        return win;
    endfunction

    task automatic random_inference(input int run);
        logic [31:0] feat;
        logic [31:0] rd;
        for (int i = 0; i < `NN_PARAM_WORDS; i++)
            params[i] = rand_param();
        load_params();
        feat = rand_bits(32);
        axi_write(FEAT_BYTE, feat, 0);
        axi_read(RESULT_BYTE, int'(rand_bits(3)), rd);
        check_val($sformatf("o_rdata[result run %0d]", run), rd, 32'(ref_predict(feat)));
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================
    initial begin : stimulus
        logic [31:0] rd;
        logic [31:0] feat;
        logic [15:0] newv;
        int          idx;
        int          k;

        lfsr_state = 16'd49147;
        rst        = 1'b1;
        i_araddr   = '0;
        i_arvalid  = 1'b0;
        i_rready   = 1'b0;
        i_awaddr   = '0;
        i_awvalid  = 1'b0;
        i_wdata    = '0;
        i_wvalid   = 1'b0;
        i_bready   = 1'b0;
        repeat (10) @(posedge ACLK);
        rst <= 1'b0;

        @(negedge ACLK);
        check_val("o_awready", 32'(o_awready), 32'd0);
        check_val("o_wready", 32'(o_wready), 32'd0);
        check_val("o_bvalid", 32'(o_bvalid), 32'd0);
        check_val("o_arready", 32'(o_arready), 32'd0);
        check_val("o_rvalid", 32'(o_rvalid), 32'd0);

        // Feature register and parameter readback
        feat = rand_bits(32);
        axi_write(FEAT_BYTE, feat, 0);
        axi_read(FEAT_BYTE, 0, rd);
        check_val("o_rdata[features]", rd, feat);
        repeat (4) param_roundtrip(0, 0);

        for (int run = 0; run < 3; run++)
            random_inference(run);

        // Zero weights and equal biases so every class ties
        for (int i = 0; i < `NN_PARAM_WORDS; i++)
            params[i] = (i >= `NN_B1_OFS) ? 16'sh0100 : 16'sh0000;
        load_params();
        axi_read(RESULT_BYTE, 0, rd);
        check_val("o_rdata[tie]", rd, 32'd0);
        k = (int'(rand_bits(2)) % 3) + 1;
        params[`NN_B3_OFS + k] = 16'sh0200;
        axi_write(param_addr(`NN_B3_OFS + k), sext(16'h0200), 0);
        axi_read(RESULT_BYTE, 0, rd);
        check_val("o_rdata[largest bias]", rd, 32'(k));

        // BREADY and RREADY held off
        repeat (4) param_roundtrip(int'(rand_bits(4)), int'(rand_bits(4)));

        // AW and AR raised together and the write must land first
        idx  = int'(rand_bits(9)) % `NN_PARAM_WORDS;
        newv = ~params[idx];
        @(posedge ACLK);
        i_awaddr  <= param_addr(idx);
        i_wdata   <= sext(newv);
        i_awvalid <= 1'b1;
        i_wvalid  <= 1'b1;
        i_araddr  <= param_addr(idx);
        i_arvalid <= 1'b1;
        write_finish(0);
        params[idx] = newv;
        read_finish(0, rd);
        check_val("o_rdata[write before read]", rd, sext(newv));

        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: files.f
+incdir+design
design/nn_pkg.sv
design/nn_bus_if.sv
design/axil_slave_fsm.sv
design/param_mem.sv
design/infer_seq.sv
design/mac_datapath.sv
design/nn_axil_top.sv
sim/tb_nn_axil.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the testbench
BUILD_LOG=build.log
SIM_LOG=sim.log

rm -f "$SIM_LOG"
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_nn_axil -f files.f > "$BUILD_LOG" 2>&1 \
    && ./obj_dir/Vtb_nn_axil > "$SIM_LOG" 2>&1 \
    || echo "Build or simulation exited with an error, see $BUILD_LOG" >> "$SIM_LOG"
cat "$SIM_LOG"

# The log decides the result
grep -q "Finished with errors" "$SIM_LOG" && exit 1
grep -q "Finished with no errors" "$SIM_LOG" || exit 1
exit 0
